//--- design/bp_pkg.sv
package bp_pkg;

    // Table geometry
    localparam int LOCAL_INDEX_BITS   = 5; // pc[6:2], one history per branch slot
    localparam int LOCAL_HIST_BITS    = 6;
    localparam int GSHARE_INDEX_BITS  = 8; // Also the global history length
    localparam int CHOOSER_INDEX_BITS = 8; // pc[9:2]

    localparam int LOCAL_ENTRIES   = 2 ** LOCAL_INDEX_BITS;
    localparam int PATTERN_ENTRIES = 2 ** LOCAL_HIST_BITS;
    localparam int GSHARE_ENTRIES  = 2 ** GSHARE_INDEX_BITS;
    localparam int CHOOSER_ENTRIES = 2 ** CHOOSER_INDEX_BITS;

    // Direction counter, upper bit is the taken prediction
    typedef enum logic [1:0] {
        STRONG_NOT_TAKEN = 2'b00,
        WEAK_NOT_TAKEN   = 2'b01,
        WEAK_TAKEN       = 2'b10,
        STRONG_TAKEN     = 2'b11
    } counter_t;

    // Chooser counter, upper bit selects gshare
    typedef enum logic [1:0] {
        STRONG_LOCAL  = 2'b00,
        WEAK_LOCAL    = 2'b01,
        WEAK_GLOBAL   = 2'b10,
        STRONG_GLOBAL = 2'b11
    } chooser_t;

    // Saturating step toward the resolved outcome
    function automatic counter_t counter_next(input counter_t c, input logic taken);
        if (taken) begin
            return (c == STRONG_TAKEN) ? STRONG_TAKEN : counter_t'(c + 2'd1);
        end
        return (c == STRONG_NOT_TAKEN) ? STRONG_NOT_TAKEN : counter_t'(c - 2'd1);
    endfunction

    function automatic chooser_t chooser_next(input chooser_t c, input logic toward_global);
        if (toward_global) begin
            return (c == STRONG_GLOBAL) ? STRONG_GLOBAL : chooser_t'(c + 2'd1);
        end
        return (c == STRONG_LOCAL) ? STRONG_LOCAL : chooser_t'(c - 2'd1);
    endfunction

    function automatic logic [LOCAL_INDEX_BITS-1:0] local_index(input logic [31:0] pc);
        return pc[LOCAL_INDEX_BITS+1:2]; // Word aligned PCs
    endfunction

    function automatic logic [GSHARE_INDEX_BITS-1:0] gshare_index(
        input logic [31:0]                  pc,
        input logic [GSHARE_INDEX_BITS-1:0] hist
    );
        return pc[GSHARE_INDEX_BITS+1:2] ^ hist;
    endfunction

    function automatic logic [CHOOSER_INDEX_BITS-1:0] chooser_index(input logic [31:0] pc);
        return pc[CHOOSER_INDEX_BITS+1:2];
    endfunction

endpackage

//--- design/branch_req_if.sv
`timescale 1ns/100ps

// Prediction lookup and resolved-branch update, shared by all predictor blocks
interface branch_req_if;

    logic [31:0] predict_pc;   // Lookup address, read combinationally
    logic        update_valid; // One-cycle strobe, never back-pressured
    logic [31:0] update_pc;
    logic        update_taken; // Resolved outcome

    // Driving side
    modport source (
        output predict_pc,
        output update_valid,
        output update_pc,
        output update_taken
    );

    // Component predictors and the chooser only listen
    modport predictor (
        input predict_pc,
        input update_valid,
        input update_pc,
        input update_taken
    );

endinterface

//--- design/local_predictor.sv
`timescale 1ns/100ps

module local_predictor import bp_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    branch_req_if.predictor       req,
    output logic                  predict_taken,
    output logic                  update_pred
);

    // Per-branch history shift registers
    logic [LOCAL_HIST_BITS-1:0] bht [LOCAL_ENTRIES];

    // One pattern table per branch slot, indexed by that branch's history
    counter_t pht [LOCAL_ENTRIES][PATTERN_ENTRIES];

    logic [LOCAL_INDEX_BITS-1:0] pred_idx;
    logic [LOCAL_INDEX_BITS-1:0] upd_idx;
    logic [LOCAL_HIST_BITS-1:0]  pred_hist;
    logic [LOCAL_HIST_BITS-1:0]  upd_hist;
    counter_t                    pred_ctr;
    counter_t                    upd_ctr;

    // Lookup port
    always_comb begin
        pred_idx  = local_index(req.predict_pc);
        pred_hist = bht[pred_idx];
        pred_ctr  = pht[pred_idx][pred_hist];
    end

    // Update port, reads state from before the update edge
    always_comb begin
        upd_idx  = local_index(req.update_pc);
        upd_hist = bht[upd_idx];
        upd_ctr  = pht[upd_idx][upd_hist];
    end

    assign predict_taken = pred_ctr[1];
    assign update_pred   = upd_ctr[1]; // Used by the chooser for training

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < LOCAL_ENTRIES; i++) begin
                bht[i] <= '0;
                for (int j = 0; j < PATTERN_ENTRIES; j++) begin
                    pht[i][j] <= WEAK_NOT_TAKEN;
                end
            end
        end else if (req.update_valid) begin
            // Counter selected by the pre-update history
            pht[upd_idx][upd_hist] <= counter_next(upd_ctr, req.update_taken);

            // Newest outcome enters at bit 0
            bht[upd_idx] <= {upd_hist[LOCAL_HIST_BITS-2:0], req.update_taken};
        end
    end

endmodule

//--- design/gshare_predictor.sv
`timescale 1ns/100ps

module gshare_predictor import bp_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    branch_req_if.predictor       req,
    output logic                  predict_taken,
    output logic                  update_pred
);

    logic [GSHARE_INDEX_BITS-1:0] ghr; // Global history, newest outcome in bit 0
    counter_t                     pht [GSHARE_ENTRIES];

    logic [GSHARE_INDEX_BITS-1:0] pred_idx;
    logic [GSHARE_INDEX_BITS-1:0] upd_idx;
    counter_t                     pred_ctr;
    counter_t                     upd_ctr;

    // Both ports hash with the current history
    always_comb begin
        pred_idx = gshare_index(req.predict_pc, ghr);
        upd_idx  = gshare_index(req.update_pc, ghr);
        pred_ctr = pht[pred_idx];
        upd_ctr  = pht[upd_idx];
    end

    assign predict_taken = pred_ctr[1];
    assign update_pred   = upd_ctr[1];

    // History register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ghr <= '0;
        end else if (req.update_valid) begin
            ghr <= {ghr[GSHARE_INDEX_BITS-2:0], req.update_taken};
        end
    end

    // Counter table
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < GSHARE_ENTRIES; i++) begin
                pht[i] <= WEAK_NOT_TAKEN;
            end
        end else if (req.update_valid) begin
            pht[upd_idx] <= counter_next(upd_ctr, req.update_taken); // Index from old ghr
        end
    end

endmodule

//--- design/tournament_chooser.sv
`timescale 1ns/100ps

module tournament_chooser import bp_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    branch_req_if.predictor       req,
    input  logic                  local_predict,
    input  logic                  global_predict,
    input  logic                  local_update_pred,
    input  logic                  global_update_pred,
    output logic                  prediction,
    output logic                  use_global
);

    chooser_t sel_table [CHOOSER_ENTRIES];

    logic [CHOOSER_INDEX_BITS-1:0] pred_idx;
    logic [CHOOSER_INDEX_BITS-1:0] upd_idx;
    chooser_t                      pred_sel;
    chooser_t                      upd_sel;
    logic                          disagree;
    logic                          global_right;

    always_comb begin
        pred_idx = chooser_index(req.predict_pc);
        upd_idx  = chooser_index(req.update_pc);
        pred_sel = sel_table[pred_idx];
        upd_sel  = sel_table[upd_idx];
    end

    // Final direction
    assign use_global = pred_sel[1];
    assign prediction = use_global ? global_predict : local_predict;

    // Training only matters when the components differ
    assign disagree     = local_update_pred ^ global_update_pred;
    assign global_right = (global_update_pred == req.update_taken);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < CHOOSER_ENTRIES; i++) begin
                sel_table[i] <= WEAK_LOCAL; // Start leaning local
            end
        end else if (req.update_valid && disagree) begin
            sel_table[upd_idx] <= chooser_next(upd_sel, global_right);
        end
    end

endmodule

//--- design/branch_predictor_top.sv
`timescale 1ns/100ps

module branch_predictor_top (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] predict_pc,
    input  logic        update_valid,
    input  logic [31:0] update_pc,
    input  logic        update_taken,
    output logic        prediction,
    output logic        use_global
);

    branch_req_if req ();

    // Plain ports onto the shared request bundle
    assign req.predict_pc   = predict_pc;
    assign req.update_valid = update_valid;
    assign req.update_pc    = update_pc;
    assign req.update_taken = update_taken;

    logic local_predict;
    logic local_update_pred;
    logic global_predict;
    logic global_update_pred;

    local_predictor u_local (
        .clk           (clk),
        .rst           (rst),
        .req           (req),
        .predict_taken (local_predict),
        .update_pred   (local_update_pred)
    );

    gshare_predictor u_gshare (
        .clk           (clk),
        .rst           (rst),
        .req           (req),
        .predict_taken (global_predict),
        .update_pred   (global_update_pred)
    );

    // Picks between the two and learns from their disagreements
    tournament_chooser u_chooser (
        .clk                (clk),
        .rst                (rst),
        .req                (req),
        .local_predict      (local_predict),
        .global_predict     (global_predict),
        .local_update_pred  (local_update_pred),
        .global_update_pred (global_update_pred),
        .prediction         (prediction),
        .use_global         (use_global)
    );

endmodule

//--- tests/bp_ref_model.svh
`ifndef BP_REF_MODEL_SVH
`define BP_REF_MODEL_SVH

// Model copy of the predictor state
logic [LOCAL_HIST_BITS-1:0]   bht_model [LOCAL_ENTRIES];
counter_t                     local_model [LOCAL_ENTRIES][PATTERN_ENTRIES];
logic [GSHARE_INDEX_BITS-1:0] ghr_model;                  // Newest outcome in bit 0
counter_t                     gshare_model [GSHARE_ENTRIES];
logic [1:0]                   chooser_model [CHOOSER_ENTRIES]; // Upper bit picks gshare
logic [31:0]                  lfsr_state;

function automatic void reset_model();
    for (int i = 0; i < LOCAL_ENTRIES; i++) begin
        bht_model[i] = '0;
        for (int j = 0; j < PATTERN_ENTRIES; j++) begin
            local_model[i][j] = WEAK_NOT_TAKEN;
        end
    end
    for (int i = 0; i < GSHARE_ENTRIES; i++) begin
        gshare_model[i] = WEAK_NOT_TAKEN;
    end
    for (int i = 0; i < CHOOSER_ENTRIES; i++) begin
        chooser_model[i] = WEAK_LOCAL;
    end
    ghr_model = '0;
endfunction

// Local component, history of the branch selects its counter
function automatic logic local_says(input logic [31:0] pc);
    logic [LOCAL_INDEX_BITS-1:0] idx;
    idx = local_index(pc);
    return local_model[idx][bht_model[idx]][1];
endfunction

function automatic logic gshare_says(input logic [31:0] pc);
    return gshare_model[gshare_index(pc, ghr_model)][1];
endfunction

// Returns {use_global, prediction} for a lookup PC
function automatic logic [1:0] expected_outcome(input logic [31:0] pc);
    logic glob;
    logic pred;
    glob = chooser_model[pc[CHOOSER_INDEX_BITS+1:2]][1];
    pred = glob ? gshare_says(pc) : local_says(pc);
    return {glob, pred};
endfunction

function automatic void train_model(input logic [31:0] pc, input logic taken);
    logic [LOCAL_INDEX_BITS-1:0]   idx;
    logic [LOCAL_HIST_BITS-1:0]    hist;
    logic [GSHARE_INDEX_BITS-1:0]  gidx;
    logic [CHOOSER_INDEX_BITS-1:0] cidx;
    logic                          lp;
    logic                          gp;
    logic [1:0]                    sel;
    lp   = local_says(pc); // Both component views come from the old state
    gp   = gshare_says(pc);
    idx  = local_index(pc);
    hist = bht_model[idx];
    local_model[idx][hist] = counter_next(local_model[idx][hist], taken);
    bht_model[idx] = {hist[LOCAL_HIST_BITS-2:0], taken};
    gidx = gshare_index(pc, ghr_model);
    gshare_model[gidx] = counter_next(gshare_model[gidx], taken);
    ghr_model = {ghr_model[GSHARE_INDEX_BITS-2:0], taken};
    if (lp != gp) begin
        cidx = pc[CHOOSER_INDEX_BITS+1:2];
        sel  = chooser_model[cidx];
        if (gp == taken) begin
            if (sel != 2'b11) sel = sel + 2'd1; // Toward gshare
        end else if (sel != 2'b00) begin
            sel = sel - 2'd1;
        end
        chooser_model[cidx] = sel;
    end
endfunction

// Galois LFSR, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
        return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
endfunction

function automatic logic [31:0] next_random_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v = {v[30:0], lfsr_state[0]};
        lfsr_state = lfsr_step(lfsr_state);
    end
    return v;
endfunction

function automatic logic [31:0] random_pc();
    logic [31:0] r;
    r = next_random_bits(30);
    return {r[29:0], 2'b00};
endfunction

`endif

//--- tests/tb_branch_predictor.sv
`timescale 1ns/100ps

module tb_branch_predictor import bp_pkg::*; ();

    localparam int PAIR_COUNT     = 256;
    localparam int SCORE_FROM     = 192; // Gshare is warmed up by then
    localparam int RANDOM_UPDATES = 2000;
    // Phase 5 may add one idle cycle per update
    localparam int MAX_CYCLES = 3 + 64 + 49 + 32 + 2 * PAIR_COUNT + 2 * RANDOM_UPDATES + 8;

    localparam logic [31:0] PC_TAKEN = 32'h0000_0100;
    localparam logic [31:0] PC_NOT   = 32'h0000_0204;
    localparam logic [31:0] PC_ALT   = 32'h0000_030c;
    localparam logic [31:0] PC_A     = 32'h0000_1450;
    localparam logic [31:0] PC_B     = 32'h0000_1788;

    logic        clk;
    logic        rst;
    logic [31:0] predict_pc;
    logic        update_valid;
    logic [31:0] update_pc;
    logic        update_taken;
    logic        prediction;
    logic        use_global;

    string       test_name = "reset";
    int          errors    = 0;
    int          checks    = 0;
    int          want_pred = -1; // Fixed expectation or -1
    int          want_glob = -1;
    logic        score_b   = 1'b0;
    logic        b_expect  = 1'b0;
    int          b_right   = 0;
    int          b_global  = 0;
    logic [31:0] pc_pool [16];

    `include "bp_ref_model.svh"

    branch_predictor_top uut (
        .clk          (clk),
        .rst          (rst),
        .predict_pc   (predict_pc),
        .update_valid (update_valid),
        .update_pc    (update_pc),
        .update_taken (update_taken),
        .prediction   (prediction),
        .use_global   (use_global)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Holds one set of inputs for a full cycle
    task automatic drive_cycle(input logic [31:0] look_pc, input logic valid,
                               input logic [31:0] pc, input logic taken);
        predict_pc   = look_pc;
        update_valid = valid;
        update_pc    = pc;
        update_taken = taken;
        @(posedge clk);
        #1;
    endtask

    // Model trains at the same edge as the DUT
    initial begin
        logic [1:0] model_bits;
        forever begin
            @(posedge clk);
            if (!rst && update_valid) train_model(update_pc, update_taken);
            #3.5;
            if (!rst) begin
                model_bits = expected_outcome(predict_pc);
                checks++;
                assert (prediction === model_bits[0]) else begin
                    errors++;
                    $display("ERR %s prediction expected %0b actual %0b",
                             test_name, model_bits[0], prediction);
                end
                assert (use_global === model_bits[1]) else begin
                    errors++;
                    $display("ERR %s use_global expected %0b actual %0b",
                             test_name, model_bits[1], use_global);
                end
                if (want_pred >= 0) begin
                    assert (prediction === want_pred[0]) else begin
                        errors++;
                        $display("ERR %s fixed prediction expected %0d actual %0b",
                                 test_name, want_pred, prediction);
                    end
                end
                if (want_glob >= 0) begin
                    assert (use_global === want_glob[0]) else begin
                        errors++;
                        $display("ERR %s fixed use_global expected %0d actual %0b",
                                 test_name, want_glob, use_global);
                    end
                end
                if (score_b) begin
                    if (prediction === b_expect) b_right++;
                    if (use_global === 1'b1) b_global++;
                end
            end
        end
    end

    initial begin
        logic [31:0] r;
        logic [31:0] look;
        rst          = 1'b1;
        predict_pc   = '0;
        update_valid = 1'b0;
        update_pc    = '0;
        update_taken = 1'b0;
        lfsr_state   = 32'h4ad5;
        reset_model();
        repeat (3) @(posedge clk);
        #1 rst = 1'b0;

        test_name = "after_reset";
        want_pred = 0;
        want_glob = 0;
        for (int k = 0; k < 64; k++) drive_cycle(random_pc(), 1'b0, '0, 1'b0);

        // Local history has to fill with ones before the taken counter is reached
        test_name = "always_taken";
        want_glob = -1;
        for (int k = 0; k < 24; k++) begin
            want_pred = (k >= 7) ? 1 : 0;
            drive_cycle(PC_TAKEN, 1'b1, PC_TAKEN, 1'b1);
        end
        test_name = "never_taken";
        want_pred = 0;
        for (int k = 0; k < 24; k++) drive_cycle(PC_NOT, 1'b1, PC_NOT, 1'b0);
        test_name = "taken_holds";
        want_pred = 1;
        drive_cycle(PC_TAKEN, 1'b0, '0, 1'b0);

        test_name = "alternating";
        want_glob = 0;
        for (int k = 0; k < 32; k++) begin
            want_pred = (k >= 16) ? ((k % 2 == 0) ? 1 : 0) : -1;
            drive_cycle(PC_ALT, 1'b1, PC_ALT, (k % 2 == 0));
        end

        // B repeats the last outcome of A
        test_name = "gshare_correlation";
        want_pred = -1;
        want_glob = -1;
        for (int k = 0; k < PAIR_COUNT; k++) begin
            r = next_random_bits(1);
            drive_cycle(PC_A, 1'b1, PC_A, r[0]);
            score_b  = (k >= SCORE_FROM);
            b_expect = r[0];
            drive_cycle(PC_B, 1'b1, PC_B, r[0]);
            score_b  = 1'b0;
        end
        assert (b_global >= PAIR_COUNT - SCORE_FROM - 4) else begin
            errors++;
            $display("ERR %s use_global count expected at least %0d actual %0d",
                     test_name, PAIR_COUNT - SCORE_FROM - 4, b_global);
        end
        assert (b_right >= PAIR_COUNT - SCORE_FROM - 8) else begin
            errors++;
            $display("ERR %s correct count expected at least %0d actual %0d",
                     test_name, PAIR_COUNT - SCORE_FROM - 8, b_right);
        end

        test_name = "random_mix";
        for (int i = 0; i < 16; i++) pc_pool[i] = random_pc();
        for (int n = 0; n < RANDOM_UPDATES; n++) begin
            r = next_random_bits(1);
            if (r[0]) drive_cycle(random_pc(), 1'b0, '0, 1'b0); // Idle cycle
            r = next_random_bits(10);
            look = r[8] ? pc_pool[r[7:4]] : random_pc();
            drive_cycle(look, 1'b1, pc_pool[r[3:0]], r[9]);
        end

        $display("Checked %0d cycles, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        #(MAX_CYCLES * 4 * 2);
        $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES * 2);
        $display("Checked %0d cycles, %0d errors", checks, errors);
        $display("Something failed");
        $finish;
    end

endmodule

//--- files.f
+incdir+tests
design/bp_pkg.sv
design/branch_req_if.sv
design/local_predictor.sv
design/gshare_predictor.sv
design/tournament_chooser.sv
design/branch_predictor_top.sv
tests/tb_branch_predictor.sv

//--- run_sim.sh
#!/bin/sh
# Compiles and runs the branch predictor testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_branch_predictor \
    -f files.f -o sim_bp

./obj_dir/sim_bp | tee sim.log

if grep -qx "Everything OK" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
